/* all.f */
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/pipeline.sv
testbench/pipeline_tb.sv

/* Makefile */
# Verilator build of the pipeline testbench

.PHONY: run clean

run: obj_dir/Vpipeline_tb
	./obj_dir/Vpipeline_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "TEST FAILED" sim.log

# Rebuilt only when a source or the file list changes
obj_dir/Vpipeline_tb: all.f $(wildcard source/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert --top-module pipeline_tb -f all.f -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log

/* testbench/pipeline_tb.sv */
// Testbench: clock, reset, memory model, random programs, instruction-set model and checks
`timescale 1ns/1ps
`default_nettype none

module pipeline_tb
  import isa_pkg::*, pipe_pkg::*;
();

  localparam int MEM_WORDS   = 1024;
  localparam int DATA_FIRST  = 512;      // Word index of 0x1000
  localparam int PROLOGUE    = 31;       // One ADDI per register
  localparam int TAIL_CYCLES = 8;        // Quiet cycles watched after the last commit
  localparam logic [5:0] BAD_OPCODE = 6'h01;

  logic         clock = 1'b0;
  logic         reset;
  mem_request_t mem_request;
  word_t        mem_read_data;
  commit_t      commit;
  status_t      status;

  word_t        dut_mem   [MEM_WORDS];
  word_t        image     [MEM_WORDS];   // Memory contents restored in reset
  word_t        model_mem [MEM_WORDS];
  inst_t        program_q [$];
  commit_t      expect_q  [$];           // Retired instructions in order
  mem_request_t store_q   [$];
  int           value_errors = 0;
  int           other_errors = 0;
  logic         timed_out = 1'b0;

  pipeline i_pipeline (
    .clock         (clock),
    .reset         (reset),
    .mem_request   (mem_request),
    .mem_read_data (mem_read_data),
    .commit        (commit),
    .status        (status)
  );

  always #50 clock = ~clock;  // 100 ns period

  ////////////////////
  // Memory model
  ////////////////////
  assign mem_read_data = dut_mem[mem_request.addr[12:3]];  // Same-cycle read

  always @(posedge clock)
  begin
    if (reset)
      dut_mem <= image;
    else if (mem_request.command == BUS_STORE)
      dut_mem[mem_request.addr[12:3]] <= mem_request.data;
  end

  task automatic compare_value(string name, word_t got, word_t want);
    assert (got === want)
    else
    begin
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
      value_errors++;
    end
  endtask

  task automatic report_problem(string text);
    $display("Failure at %0t ns: %s", $time, text);
    other_errors++;
  endtask

  ////////////////////
  // Program generator
  ////////////////////
  function automatic inst_t alu_inst(alu_func_t func, reg_idx_t ra, reg_idx_t rb, reg_idx_t rc);
    return {OP_ALU, ra, rb, rc, func};
  endfunction

  function automatic inst_t imm_inst(opcode_t op, reg_idx_t ra, reg_idx_t rb, logic [15:0] imm);
    return {op, ra, rb, imm};
  endfunction

  // Zero often enough for BEQ to be taken
  function automatic reg_idx_t pick_reg();
    if ($urandom_range(3) == 0)
      return ZERO_REG;
    return 5'($urandom_range(31, 1));
  endfunction

  function automatic alu_func_t random_func();
    case ($urandom_range(5))
      0:       return FUNC_ADD;
      1:       return FUNC_SUB;
      2:       return FUNC_AND;
      3:       return FUNC_OR;
      4:       return FUNC_XOR;
      default: return FUNC_SLL;
    endcase
  endfunction

  // Instruction at index k with branches landing no further than last_idx
  function automatic inst_t random_inst(int k, int last_idx);
    logic [15:0] offset;
    logic [15:0] data_addr;
    offset    = 16'($urandom_range(last_idx - k - 1));
    data_addr = 16'h1000 + 16'(8 * $urandom_range(DATA_FIRST - 1));  // Data region
    case ($urandom_range(5))
      0:       return alu_inst(random_func(), pick_reg(), pick_reg(), 5'($urandom_range(31)));
      1:       return imm_inst(OP_ADDI, pick_reg(), 5'($urandom_range(31)), 16'($urandom));
      2:       return imm_inst(OP_LOAD, ZERO_REG, 5'($urandom_range(31)), data_addr);
      3:       return imm_inst(OP_STORE, ZERO_REG, pick_reg(), data_addr);
      4:       return imm_inst(OP_BEQ, pick_reg(), ZERO_REG, offset);
      default: return imm_inst(OP_JUMP, ZERO_REG, 5'($urandom_range(31)), offset);
    endcase
  endfunction

  task automatic build_program(int n_random, inst_t last);
    int r;
    int k;
    program_q.delete();
    for (r = 1; r < REG_COUNT; r++)
      program_q.push_back(imm_inst(OP_ADDI, ZERO_REG, 5'(r), 16'($urandom)));  // No X reads
    for (k = 0; k < n_random; k++)
      program_q.push_back(random_inst(program_q.size(), PROLOGUE + n_random));
    program_q.push_back(last);
    for (k = 0; k < MEM_WORDS; k++)
      image[k] = {32'(k) ^ 32'h9e37_79b9, 32'(k * 8) * 32'h0001_0003};  // Fill from address
    for (k = 0; k < program_q.size(); k++)
      image[k] = {32'h0, program_q[k]};
  endtask

  ////////////////////
  // Instruction-set model
  ////////////////////
  function automatic word_t alu_model(logic [10:0] func, word_t a, word_t b);
    case (func)
      FUNC_ADD: return a + b;
      FUNC_SUB: return a - b;
      FUNC_AND: return a & b;
      FUNC_OR:  return a | b;
      FUNC_XOR: return a ^ b;
      FUNC_SLL: return a << b[5:0];
      default:  return '0;
    endcase
  endfunction

  // Runs the program to its end and queues commits and stores
  task automatic build_trace(output status_t final_status);
    word_t        regs [REG_COUNT];
    word_t        pc;
    word_t        next_pc;
    word_t        imm;
    word_t        ra_value;
    word_t        rb_value;
    word_t        addr;
    inst_t        inst;
    commit_t      rec;
    mem_request_t store;
    logic         running;
    int           i;
    for (i = 0; i < REG_COUNT; i++)
      regs[i] = '0;
    model_mem = image;
    expect_q.delete();
    store_q.delete();
    pc           = '0;
    running      = 1'b1;
    final_status = STATUS_RUNNING;
    while (running)
    begin
      inst      = model_mem[pc[12:3]][31:0];
      imm       = {{48{inst[15]}}, inst[15:0]};
      ra_value  = regs[inst[25:21]];
      rb_value  = regs[inst[20:16]];
      addr      = ra_value + imm;
      rec       = '0;
      rec.valid = 1'b1;
      rec.npc   = pc + INST_STEP;
      next_pc   = rec.npc;
      case (inst[31:26])
        OP_ALU:
        begin
          if (inst[10:0] inside {FUNC_ADD, FUNC_SUB, FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_SLL})
          begin
            rec.wr_idx  = inst[15:11];
            rec.wr_data = alu_model(inst[10:0], ra_value, rb_value);
          end
          else
          begin
            running      = 1'b0;             // Unknown function is illegal
            final_status = STATUS_ILLEGAL;
          end
        end
        OP_ADDI:
        begin
          rec.wr_idx  = inst[20:16];
          rec.wr_data = addr;
        end
        OP_LOAD:
        begin
          rec.wr_idx  = inst[20:16];
          rec.wr_data = model_mem[addr[12:3]];
        end
        OP_STORE:
        begin
          store.command = BUS_STORE;
          store.addr    = addr;
          store.data    = rb_value;
          store_q.push_back(store);
          model_mem[addr[12:3]] = rb_value;
        end
        OP_BEQ:
        begin
          if (ra_value == '0)
            next_pc = rec.npc + (imm << 3);   // Taken on zero
        end
        OP_JUMP:
        begin
          rec.wr_idx  = inst[20:16];           // Link
          rec.wr_data = rec.npc;
          next_pc     = rec.npc + (imm << 3);
        end
        OP_HALT:
        begin
          running      = 1'b0;
          final_status = STATUS_HALTED;
        end
        default:
        begin
          running      = 1'b0;
          final_status = STATUS_ILLEGAL;
        end
      endcase
      rec.wr_en = (rec.wr_idx != ZERO_REG);
      if (rec.wr_en)
        regs[rec.wr_idx] = rec.wr_data;
      expect_q.push_back(rec);
      pc = next_pc;
    end
  endtask

  ////////////////////
  // One run from reset
  ////////////////////
  task automatic run_program();
    commit_t      expected;
    mem_request_t store;
    status_t      final_status;
    int           cycle;
    int           limit;
    int           last_commit;
    int           expected_cycle;
    int           tail;
    int           i;
    logic         done;
    build_trace(final_status);
    limit = 4 * program_q.size() + 20;
    reset = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset       = 1'b0;
    cycle       = 0;
    last_commit = 0;
    tail        = 0;
    done        = 1'b0;
    while (!done)
    begin
      @(negedge clock);                      // Outputs settled here
      cycle++;
      if (expect_q.size() > 0)
        compare_value("status", 64'(status), 64'(STATUS_RUNNING));
      if (commit.valid)
      begin
        assert (expect_q.size() > 0)
        else
          report_problem("a commit arrived after the program had ended");
        if (expect_q.size() > 0)
        begin
          expected       = expect_q.pop_front();
          expected_cycle = (last_commit == 0) ? 4 : last_commit + 4;
          assert (cycle == expected_cycle)
          else
            report_problem($sformatf("commit came in cycle %0d after reset, expected %0d",
                                     cycle, expected_cycle));
          compare_value("commit.wr_en", 64'(commit.wr_en), 64'(expected.wr_en));
          compare_value("commit.wr_idx", 64'(commit.wr_idx), 64'(expected.wr_idx));
          compare_value("commit.npc", commit.npc, expected.npc);
          if (expected.wr_en)
            compare_value("commit.wr_data", commit.wr_data, expected.wr_data);
        end
        last_commit = cycle;
      end
      if (mem_request.command == BUS_STORE)
      begin
        assert (store_q.size() > 0)
        else
          report_problem("a store appeared that the program does not make");
        if (store_q.size() > 0)
        begin
          store = store_q.pop_front();
          compare_value("mem_request.addr", mem_request.addr, store.addr);
          compare_value("mem_request.data", mem_request.data, store.data);
        end
      end
      // Stopped machine keeps a quiet bus and the final status
      if (expect_q.size() == 0 && cycle > last_commit)
      begin
        compare_value("mem_request.command", 64'(mem_request.command), 64'(BUS_NONE));
        compare_value("status", 64'(status), 64'(final_status));
        tail++;
        done = (tail >= TAIL_CYCLES);
      end
      assert (cycle < limit)
      else
      begin
        report_problem($sformatf("timeout after %0d cycles with %0d commits missing",
                                 cycle, expect_q.size()));
        timed_out = 1'b1;
        done      = 1'b1;
      end
    end
    assert (store_q.size() == 0)
    else
      report_problem("some expected stores never appeared on the bus");
    for (i = DATA_FIRST; i < MEM_WORDS; i++)
      compare_value($sformatf("dut_mem[%0d]", i), dut_mem[i], model_mem[i]);
  endtask

  initial
  begin
    reset = 1'b1;
    void'($urandom(32'h5ce64c18));
    build_program(40, {OP_HALT, 26'h0});
    run_program();
    if (!timed_out)
    begin
      build_program(8, {BAD_OPCODE, 26'($urandom)});  // Ends in an illegal opcode
      run_program();
    end
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* source/pipeline.sv */
// Top level: stage instances, shared memory port, writeback and status
`timescale 1ns/1ps
`default_nettype none

module pipeline
  import isa_pkg::*, pipe_pkg::*;
(
  input  wire logic  clock,
  input  wire logic  reset,
  output mem_request_t mem_request,
  input  wire word_t mem_read_data,
  output commit_t    commit,
  output status_t    status
);

  if_id_t       if_id;
  id_ex_t       id_ex;
  ex_mem_t      ex_mem;
  mem_wb_t      mem_wb;
  word_t        fetch_addr;
  logic         fetch_active;
  mem_request_t fetch_request;
  mem_request_t data_request;

  fetch_stage i_fetch_stage (
    .clock        (clock),
    .reset        (reset),
    .commit_stage (mem_wb),
    .fetch_addr   (fetch_addr),
    .fetch_active (fetch_active),
    .fetch_data   (mem_read_data),
    .if_id        (if_id)
  );

  decode_stage i_decode_stage (
    .clock  (clock),
    .reset  (reset),
    .if_id  (if_id),
    .commit (commit),
    .id_ex  (id_ex)
  );

  execute_stage i_execute_stage (
    .clock  (clock),
    .reset  (reset),
    .id_ex  (id_ex),
    .ex_mem (ex_mem)
  );

  memory_stage i_memory_stage (
    .clock        (clock),
    .reset        (reset),
    .ex_mem       (ex_mem),
    .data_request (data_request),
    .load_data    (mem_read_data),
    .mem_wb       (mem_wb)
  );

  ////////////////////
  // Memory port
  ////////////////////
  assign fetch_request.command = fetch_active ? BUS_LOAD : BUS_NONE;
  assign fetch_request.addr    = fetch_addr;
  assign fetch_request.data    = '0;

  // Data side wins whenever it asks
  assign mem_request = (data_request.command != BUS_NONE) ? data_request : fetch_request;

  ////////////////////
  // Writeback
  ////////////////////
  assign commit.valid   = mem_wb.ctrl.valid;
  assign commit.wr_en   = mem_wb.ctrl.valid && (mem_wb.ctrl.dest_idx != ZERO_REG);
  assign commit.wr_idx  = mem_wb.ctrl.dest_idx;
  assign commit.wr_data = mem_wb.ctrl.uncond_branch ? mem_wb.npc : mem_wb.result; // Link
  assign commit.npc     = mem_wb.npc;

  // Status sticks until reset
  always_ff @(posedge clock)
  begin
    if (reset)
      status <= STATUS_RUNNING;
    else if (mem_wb.ctrl.valid && mem_wb.ctrl.illegal)
      status <= STATUS_ILLEGAL;
    else if (mem_wb.ctrl.valid && mem_wb.ctrl.halt)
      status <= STATUS_HALTED;
  end

  // Issue rule keeps fetch and data access in different cycles
  a_port_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(fetch_active && data_request.command != BUS_NONE));

endmodule

`default_nettype wire

/* source/memory_stage.sv */
// Memory stage: data-side load and store requests, load result, MEM/WB register
`timescale 1ns/1ps
`default_nettype none

module memory_stage
  import isa_pkg::*, pipe_pkg::*;
(
  input  wire logic    clock,
  input  wire logic    reset,
  input  wire ex_mem_t ex_mem,
  output mem_request_t data_request,
  input  wire word_t   load_data,   // Same-cycle answer
  output mem_wb_t      mem_wb
);

  // Data side request, BUS_NONE for everything but loads and stores
  always_comb
  begin
    data_request.addr = ex_mem.alu_result;
    data_request.data = ex_mem.rb_value;
    if (ex_mem.ctrl.valid && ex_mem.ctrl.rd_mem)
      data_request.command = BUS_LOAD;
    else if (ex_mem.ctrl.valid && ex_mem.ctrl.wr_mem)
      data_request.command = BUS_STORE;   // Memory writes at the rising edge
    else
      data_request.command = BUS_NONE;
  end

  ////////////////////
  // MEM/WB register
  ////////////////////
  always_ff @(posedge clock)
  begin
    mem_wb.npc    <= ex_mem.npc;
    mem_wb.result <= ex_mem.ctrl.rd_mem ? load_data : ex_mem.alu_result;
    if (reset)
    begin
      mem_wb.take_branch <= 1'b0;
      mem_wb.ctrl        <= '0;
    end
    else
    begin
      mem_wb.take_branch <= ex_mem.take_branch;
      mem_wb.ctrl        <= ex_mem.ctrl;
    end
  end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
// Execute stage: operand select, ALU, branch decision and target, EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import isa_pkg::*, pipe_pkg::*;
(
  input  wire logic   clock,
  input  wire logic   reset,
  input  wire id_ex_t id_ex,
  output ex_mem_t     ex_mem
);

  word_t imm;        // Sign-extended immediate
  word_t opb;
  word_t alu_out;
  word_t target;     // NPC + imm * 8
  logic  is_branch;
  logic  take_branch;

  assign imm = {{(WORD_WIDTH-IMM_WIDTH){id_ex.inst[IMM_WIDTH-1]}}, id_ex.inst[IMM_WIDTH-1:0]};
  assign opb = id_ex.ctrl.opb_is_imm ? imm : id_ex.rb_value;

  always_comb
  begin
    case (id_ex.ctrl.alu_func)
      FUNC_ADD: alu_out = id_ex.ra_value + opb;  // Also load/store address
      FUNC_SUB: alu_out = id_ex.ra_value - opb;
      FUNC_AND: alu_out = id_ex.ra_value & opb;
      FUNC_OR:  alu_out = id_ex.ra_value | opb;
      FUNC_XOR: alu_out = id_ex.ra_value ^ opb;
      FUNC_SLL: alu_out = id_ex.ra_value << opb[5:0];
      default:  alu_out = '0;
    endcase
  end

  assign target      = id_ex.npc + (imm << 3);
  assign is_branch   = id_ex.ctrl.cond_branch || id_ex.ctrl.uncond_branch;
  assign take_branch = id_ex.ctrl.valid &&
                       (id_ex.ctrl.uncond_branch ||
                        (id_ex.ctrl.cond_branch && id_ex.ra_value == '0)); // Branch on zero

  ////////////////////
  // EX/MEM register
  ////////////////////
  always_ff @(posedge clock)
  begin
    ex_mem.npc        <= id_ex.npc;
    ex_mem.alu_result <= is_branch ? target : alu_out;
    ex_mem.rb_value   <= id_ex.rb_value;
    if (reset)
    begin
      ex_mem.take_branch <= 1'b0;
      ex_mem.ctrl        <= '0;
    end
    else
    begin
      ex_mem.take_branch <= take_branch;
      ex_mem.ctrl        <= id_ex.ctrl;
    end
  end

  // Relies on fetch only ever producing aligned NPCs
  a_target_aligned: assert property (@(posedge clock) disable iff (reset)
    ex_mem.take_branch |-> ex_mem.alu_result[2:0] == 3'b000);

endmodule

`default_nettype wire

/* source/decode_stage.sv */
// Decode stage: instruction decoder, register file with writeback port, ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import isa_pkg::*, pipe_pkg::*;
(
  input  wire logic    clock,
  input  wire logic    reset,
  input  wire if_id_t  if_id,
  input  wire commit_t commit,   // Writeback port
  output id_ex_t       id_ex
);

  opcode_t   opcode;
  alu_func_t func;
  reg_idx_t  ra_idx;
  reg_idx_t  rb_idx;
  reg_idx_t  rc_idx;
  control_t  ctrl;
  word_t     ra_value;
  word_t     rb_value;
  word_t     regs [REG_COUNT];

  assign opcode = opcode_t'(if_id.inst[OPCODE_LSB +: 6]);
  assign func   = alu_func_t'(if_id.inst[10:0]);
  assign ra_idx = if_id.inst[RA_LSB +: 5];
  assign rb_idx = if_id.inst[RB_LSB +: 5];
  assign rc_idx = if_id.inst[RC_LSB +: 5];

  ////////////////////
  // Decoder
  ////////////////////
  always_comb
  begin
    ctrl       = '0;           // Defaults to add with no memory and no write
    ctrl.valid = if_id.valid;
    case (opcode)
      OP_ALU:
      begin
        ctrl.dest_idx = rc_idx;
        case (func)
          FUNC_ADD, FUNC_SUB, FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_SLL:
            ctrl.alu_func = func;
          default:
          begin
            ctrl.illegal  = if_id.valid;
            ctrl.dest_idx = ZERO_REG;   // Illegal writes nothing
          end
        endcase
      end
      OP_ADDI:
      begin
        ctrl.opb_is_imm = 1'b1;
        ctrl.dest_idx   = rb_idx;
      end
      OP_LOAD:
      begin
        ctrl.opb_is_imm = 1'b1;         // Address = ra + imm
        ctrl.rd_mem     = 1'b1;
        ctrl.dest_idx   = rb_idx;
      end
      OP_STORE:
      begin
        ctrl.opb_is_imm = 1'b1;
        ctrl.wr_mem     = 1'b1;
      end
      OP_BEQ:  ctrl.cond_branch = 1'b1;
      OP_JUMP:
      begin
        ctrl.uncond_branch = 1'b1;
        ctrl.dest_idx      = rb_idx;    // Link register gets NPC
      end
      OP_HALT: ctrl.halt = if_id.valid;
      default: ctrl.illegal = if_id.valid;
    endcase
  end

  ////////////////////
  // Register file
  ////////////////////
  assign ra_value = (ra_idx == ZERO_REG) ? '0 : regs[ra_idx];
  assign rb_value = (rb_idx == ZERO_REG) ? '0 : regs[rb_idx];

  always_ff @(posedge clock)
  begin
    if (commit.wr_en)
      regs[commit.wr_idx] <= commit.wr_data; // Read back in the next fetch's decode
  end

  ////////////////////
  // ID/EX register
  ////////////////////
  always_ff @(posedge clock)
  begin
    id_ex.npc      <= if_id.npc;
    id_ex.inst     <= if_id.inst;
    id_ex.ra_value <= ra_value;
    id_ex.rb_value <= rb_value;
    if (reset || !if_id.valid)
      id_ex.ctrl <= '0;          // Bubble
    else
      id_ex.ctrl <= ctrl;
  end

  // Register write never meets a decode read in the same cycle
  a_write_not_in_decode: assert property (@(posedge clock) disable iff (reset)
    commit.wr_en |-> !if_id.valid);

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
// Fetch stage: issue rule, next address, stop after halt or illegal, IF/ID register
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
  import isa_pkg::*, pipe_pkg::*;
(
  input  wire logic    clock,
  input  wire logic    reset,
  input  wire mem_wb_t commit_stage,  // Instruction now in writeback
  output word_t        fetch_addr,
  output logic         fetch_active,  // Fetch request this cycle
  input  wire word_t   fetch_data,
  output if_id_t       if_id
);

  logic start;     // First cycle out of reset
  logic stopped;   // Halt or illegal has committed
  logic finishing; // Committing inst ends the program
  logic go_on;     // Committing inst lets the next one in

  assign finishing = commit_stage.ctrl.valid &&
                     (commit_stage.ctrl.halt || commit_stage.ctrl.illegal);
  assign go_on     = commit_stage.ctrl.valid && !finishing;

  // One inst in flight, so issue only on start or at writeback
  assign fetch_active = !stopped && (start || go_on);

  // Program counter comes from the inst in writeback
  always_comb
  begin
    if (start)
      fetch_addr = '0;                      // Reset vector
    else if (commit_stage.take_branch)
      fetch_addr = commit_stage.result;     // Branch target
    else
      fetch_addr = commit_stage.npc;        // Fall through
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      start   <= 1'b1;
      stopped <= 1'b0;
    end
    else
    begin
      start <= 1'b0;
      if (finishing)
        stopped <= 1'b1;                    // Sticky until reset
    end
  end

  ////////////////////
  // IF/ID register
  ////////////////////
  always_ff @(posedge clock)
  begin
    if_id.npc  <= fetch_addr + INST_STEP;
    if_id.inst <= fetch_active ? fetch_data[31:0] : NOOP_INST; // Low half of word
    if (reset)
      if_id.valid <= 1'b0;
    else
      if_id.valid <= fetch_active;
  end

  // Nothing left in flight once stopped, so no issue can follow
  a_no_issue_stopped: assert property (@(posedge clock) disable iff (reset)
    stopped |-> !commit_stage.ctrl.valid);

endmodule

`default_nettype wire

/* source/pipe_pkg.sv */
// Pipeline types: bus commands, memory request, stage payloads, commit record, status
`default_nettype none

package pipe_pkg;

  import isa_pkg::*;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'd0,
    BUS_LOAD  = 2'd1,
    BUS_STORE = 2'd2
  } bus_command_t;

  // One request on the shared memory port
  typedef struct packed {
    bus_command_t command;
    word_t        addr;
    word_t        data;     // Store data
  } mem_request_t;

  // Decoded control bits, travel with the instruction
  typedef struct packed {
    alu_func_t alu_func;
    logic      opb_is_imm;
    logic      rd_mem;
    logic      wr_mem;
    logic      cond_branch;
    logic      uncond_branch;
    reg_idx_t  dest_idx;    // ZERO_REG when nothing is written
    logic      halt;
    logic      illegal;
    logic      valid;
  } control_t;

  typedef struct packed {
    word_t npc;
    inst_t inst;
    logic  valid;
  } if_id_t;

  typedef struct packed {
    word_t    npc;
    inst_t    inst;
    word_t    ra_value;
    word_t    rb_value;
    control_t ctrl;
  } id_ex_t;

  typedef struct packed {
    word_t    npc;
    word_t    alu_result;  // Also address or branch target
    word_t    rb_value;    // Store data
    logic     take_branch;
    control_t ctrl;
  } ex_mem_t;

  typedef struct packed {
    word_t    npc;
    word_t    result;
    logic     take_branch;
    control_t ctrl;
  } mem_wb_t;

  typedef struct packed {
    logic     valid;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;
    word_t    npc;
  } commit_t;

  typedef enum logic [1:0] {
    STATUS_RUNNING = 2'd0,
    STATUS_HALTED  = 2'd1,
    STATUS_ILLEGAL = 2'd2
  } status_t;

endpackage

`default_nettype wire

/* source/isa_pkg.sv */
// Instruction set: word types, field positions, opcode and ALU function encodings
`default_nettype none

package isa_pkg;

  localparam int WORD_WIDTH = 64;
  localparam int REG_COUNT  = 32;

  typedef logic [WORD_WIDTH-1:0] word_t; // Data and address word
  typedef logic [31:0]           inst_t; // One instruction
  typedef logic [4:0]            reg_idx_t;

  localparam reg_idx_t ZERO_REG = 5'd0; // Reads zero, writes dropped

  // Field positions
  localparam int OPCODE_LSB = 26;  // Bits 31..26
  localparam int RA_LSB     = 21;  // Bits 25..21
  localparam int RB_LSB     = 16;  // Bits 20..16
  localparam int RC_LSB     = 11;  // Bits 15..11
  localparam int IMM_WIDTH  = 16;  // Bits 15..0, sign extended

  localparam inst_t NOOP_INST = 32'h0000_0000; // ALU add into r0
  localparam word_t INST_STEP = 64'd8;         // One inst per 64-bit word

  // Major opcodes, anything else is illegal
  typedef enum logic [5:0] {
    OP_ALU   = 6'h00,
    OP_ADDI  = 6'h08,
    OP_LOAD  = 6'h29,
    OP_STORE = 6'h2d,
    OP_BEQ   = 6'h39,
    OP_JUMP  = 6'h34,
    OP_HALT  = 6'h3f
  } opcode_t;

  // ALU functions in the low 11 bits of OP_ALU
  typedef enum logic [10:0] {
    FUNC_ADD = 11'h000,
    FUNC_SUB = 11'h001,
    FUNC_AND = 11'h002,
    FUNC_OR  = 11'h003,
    FUNC_XOR = 11'h004,
    FUNC_SLL = 11'h005
  } alu_func_t;

endpackage

`default_nettype wire
